// ==== ras_top.f ====
+incdir+testbench
rtl/riscv_isa_pkg.sv
rtl/ras_pkg.sv
rtl/ras_event_decoder.sv
rtl/ras_stack_buffer.sv
rtl/ras_spill_engine.sv
rtl/ras_config_regs.sv
rtl/ras_top.sv
testbench/ras_tb.sv

// ==== rtl/ras_config_regs.sv ====
`timescale 1ns/1ps

module ras_config_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cfg_wr,
  input  ras_pkg::cfg_addr_t cfg_addr,
  input  logic [31:0]        cfg_din,
  output logic               ras_ena,
  output ras_pkg::addr_t     base_addr
);
  import ras_pkg::*;

  logic ctrl_wr;
  logic base_wr;

  assign ctrl_wr = cfg_wr && (cfg_addr == CFG_CTRL);
  assign base_wr = cfg_wr && (cfg_addr == CFG_BASE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ras_ena <= 1'b0;
    end else if (ctrl_wr) begin
      ras_ena <= cfg_din[CFG_ENA_BIT];
    end
  end

  // Window is word aligned, low bits dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      base_addr <= '0;
    end else if (base_wr) begin
      base_addr <= {cfg_din[31:2], 2'b00};
    end
  end

endmodule : ras_config_regs

// ==== rtl/ras_event_decoder.sv ====
`timescale 1ns/1ps

module ras_event_decoder (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     ena,
  input  logic                     ev_valid,
  input  riscv_isa_pkg::ins_t      ev_ins,
  input  logic                     ev_jal,
  input  riscv_isa_pkg::reg_idx_t  ev_rd,
  input  ras_pkg::addr_t           ev_next_addr,
  input  ras_pkg::addr_t           ev_target,
  output logic                     ev_ready,
  output logic                     op_valid,
  output ras_pkg::ras_op_e         op_kind,
  output ras_pkg::addr_t           op_addr,
  output ras_pkg::addr_t           op_target,
  input  logic                     op_ready
);
  import riscv_isa_pkg::*;
  import ras_pkg::*;

  logic running;
  logic ev_fire;
  logic is_call;
  logic is_ret;
  logic keep_op;

  // Stream opens one cycle after reset is released
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running <= 1'b0;
    end else begin
      running <= 1'b1;
    end
  end

  // Slot frees up in the same cycle the stack takes the held op
  assign ev_ready = running && (!op_valid || op_ready);
  assign ev_fire  = ev_valid && ev_ready;

  assign is_call = ev_jal && (ev_rd == LINK_REG);
  assign is_ret  = (ev_ins == RET_C_WORD) || (ev_ins == RET_JALR_WORD);

  // Unclassified events and everything while disabled are swallowed
  assign keep_op = ena && (is_call || is_ret);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_valid <= 1'b0;
      op_kind  <= OP_PUSH;
    end else if (ev_fire && keep_op) begin
      op_valid <= 1'b1;
      op_kind  <= is_call ? OP_PUSH : OP_POP;
    end else if (op_ready) begin
      op_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ev_fire && keep_op) begin
      op_addr   <= ev_next_addr;
      op_target <= ev_target;
    end
  end

endmodule : ras_event_decoder

// ==== rtl/ras_pkg.sv ====
package ras_pkg;

  // Code address carried by every stack entry
  typedef logic [31:0] addr_t;

  // On-chip stack
  localparam int STACK_DEPTH = 8;
  localparam int FILL_THRESH = 6;
  localparam int EMPTY_THRESH = 2;

  // Backing memory window, in entries
  localparam int MEM_DEPTH = 16;

  typedef logic [2:0] ptr_t;
  typedef logic [3:0] count_t;
  typedef logic [4:0] mem_count_t;

  // Config register map
  typedef logic [2:0] cfg_addr_t;

  localparam cfg_addr_t CFG_CTRL = 3'd0;
  localparam cfg_addr_t CFG_BASE = 3'd1;
  localparam int CFG_ENA_BIT = 0;

  // Operations handed from the decoder to the stack
  typedef enum logic {
    OP_PUSH,
    OP_POP
  } ras_op_e;

  // Backing memory sequencer
  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_READ
  } spill_state_e;

endpackage : ras_pkg

// ==== rtl/ras_spill_engine.sv ====
`timescale 1ns/1ps

module ras_spill_engine (
  input  logic                clk,
  input  logic                rst_n,
  input  ras_pkg::addr_t      base_addr,
  input  logic                spill_req,
  input  ras_pkg::addr_t      spill_data,
  input  logic                fill_req,
  output logic                spill_done,
  output logic                fill_done,
  output ras_pkg::addr_t      fill_data,
  output ras_pkg::mem_count_t mem_count,
  output logic                mem_rd,
  output logic                mem_wr,
  output ras_pkg::addr_t      mem_addr,
  output ras_pkg::addr_t      mem_din,
  input  ras_pkg::addr_t      mem_dout,
  input  logic                mem_rdy
);
  import ras_pkg::*;

  spill_state_e state;
  mem_count_t   mem_ptr;
  mem_count_t   fill_idx;

  logic mem_full;
  logic mem_empty;
  logic start_spill;
  logic start_fill;

  // Byte address of entry idx in the backing window
  function automatic addr_t slot_addr(addr_t base, mem_count_t idx);
    addr_t offset;
    offset = addr_t'(idx) << 2;
    return base + offset;
  endfunction

  assign mem_full  = mem_ptr == mem_count_t'(MEM_DEPTH);
  assign mem_empty = mem_ptr == '0;
  assign fill_idx  = mem_ptr - mem_count_t'(1);

  // Spill into a full window is never started, so spill_done stays low
  assign start_spill = (state == S_IDLE) && spill_req && !mem_full;
  assign start_fill  = (state == S_IDLE) && !spill_req && fill_req && !mem_empty;

  assign mem_wr     = state == S_WRITE;
  assign mem_rd     = state == S_READ;
  assign spill_done = mem_wr && mem_rdy;
  assign fill_done  = mem_rd && mem_rdy;
  assign fill_data  = mem_dout;
  assign mem_count  = mem_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      mem_ptr <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start_spill) begin
            state <= S_WRITE;
          end else if (start_fill) begin
            state   <= S_READ;
            mem_ptr <= fill_idx;
          end
        end
        S_WRITE: begin
          if (mem_rdy) begin
            state   <= S_IDLE;
            mem_ptr <= mem_ptr + mem_count_t'(1);
          end
        end
        S_READ: begin
          if (mem_rdy) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Request payload, stable for the whole handshake
  always_ff @(posedge clk) begin
    if (start_spill) begin
      mem_addr <= slot_addr(base_addr, mem_ptr);
      mem_din  <= spill_data;
    end else if (start_fill) begin
      mem_addr <= slot_addr(base_addr, fill_idx);
      mem_din  <= '0;
    end
  end

endmodule : ras_spill_engine

// ==== rtl/ras_stack_buffer.sv ====
`timescale 1ns/1ps

module ras_stack_buffer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                op_valid,
  input  ras_pkg::ras_op_e    op_kind,
  input  ras_pkg::addr_t      op_addr,
  input  ras_pkg::addr_t      op_target,
  output logic                op_ready,
  output logic                ret_valid,
  output ras_pkg::addr_t      ret_predicted,
  output logic                ret_mismatch,
  output logic                ret_underflow,
  output logic                spill_req,
  output ras_pkg::addr_t      spill_data,
  input  logic                spill_done,
  output logic                fill_req,
  input  ras_pkg::addr_t      fill_data,
  input  logic                fill_done,
  input  ras_pkg::mem_count_t mem_count,
  output logic                stack_full,
  output logic                stack_empty,
  output logic                overflow
);
  import ras_pkg::*;

  addr_t  stack_mem [STACK_DEPTH];
  ptr_t   top_ptr;
  ptr_t   bot_ptr;
  ptr_t   top_idx;
  count_t count;

  logic chip_full;
  logic chip_empty;
  logic mem_full;
  logic mem_empty;
  logic stall_push;
  logic stall_pop;
  logic push_fire;
  logic pop_fire;
  logic push_store;
  logic pop_hit;
  logic req_idle;
  addr_t top_entry;

  assign chip_full  = count == count_t'(STACK_DEPTH);
  assign chip_empty = count == '0;
  assign mem_full   = mem_count == mem_count_t'(MEM_DEPTH);
  assign mem_empty  = mem_count == '0;

  // top_ptr is the next free slot, bot_ptr the oldest entry
  assign top_idx    = top_ptr - ptr_t'(1);
  assign top_entry  = stack_mem[top_idx];
  assign spill_data = stack_mem[bot_ptr];

  // A push at full waits for a spill unless memory is full too.
  // A fill lands just below the bottom, so keep that slot free
  assign stall_push = (chip_full && !mem_full) ||
                      (fill_req && count >= count_t'(STACK_DEPTH - 1));
  // Wait for refill rather than report a false underflow.
  // Last entry may be the one being spilled
  assign stall_pop  = (chip_empty && (fill_req || !mem_empty)) ||
                      (spill_req && count == count_t'(1));

  assign op_ready   = (op_kind == OP_POP) ? !stall_pop : !stall_push;
  assign push_fire  = op_valid && op_ready && (op_kind == OP_PUSH);
  assign pop_fire   = op_valid && op_ready && (op_kind == OP_POP);
  assign push_store = push_fire && !chip_full;
  assign pop_hit    = pop_fire && !chip_empty;
  assign req_idle   = !spill_req && !fill_req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      top_ptr   <= '0;
      bot_ptr   <= '0;
      count     <= '0;
      spill_req <= 1'b0;
      fill_req  <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      count <= count + count_t'(push_store) + count_t'(fill_done)
             - count_t'(pop_hit) - count_t'(spill_done);
      if (push_store) begin
        top_ptr <= top_ptr + ptr_t'(1);
      end else if (pop_hit) begin
        top_ptr <= top_idx;
      end
      if (spill_done) begin
        bot_ptr <= bot_ptr + ptr_t'(1);
      end else if (fill_done) begin
        bot_ptr <= bot_ptr - ptr_t'(1);
      end
      if (spill_done) begin
        spill_req <= 1'b0;
      end else if (req_idle && count >= count_t'(FILL_THRESH) && !mem_full) begin
        spill_req <= 1'b1;
      end
      if (fill_done) begin
        fill_req <= 1'b0;
      end else if (req_idle && count < count_t'(EMPTY_THRESH) && !mem_empty) begin
        fill_req <= 1'b1;
      end
      if (push_fire && chip_full) begin
        overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_store) begin
      stack_mem[top_ptr] <= op_addr;
    end
    if (fill_done) begin
      stack_mem[bot_ptr - ptr_t'(1)] <= fill_data;
    end
  end

  // Result of a pop, one cycle after acceptance
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ret_valid     <= 1'b0;
      ret_mismatch  <= 1'b0;
      ret_underflow <= 1'b0;
    end else begin
      ret_valid     <= pop_fire;
      ret_mismatch  <= pop_hit && (top_entry != op_target);
      ret_underflow <= pop_fire && chip_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_fire) begin
      ret_predicted <= chip_empty ? '0 : top_entry;
    end
  end

  assign stack_full  = chip_full && mem_full;
  assign stack_empty = chip_empty && mem_empty;

endmodule : ras_stack_buffer

// ==== rtl/ras_top.sv ====
`timescale 1ns/1ps

module ras_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    ev_valid,
  input  riscv_isa_pkg::ins_t     ev_ins,
  input  logic                    ev_jal,
  input  riscv_isa_pkg::reg_idx_t ev_rd,
  input  ras_pkg::addr_t          ev_next_addr,
  input  ras_pkg::addr_t          ev_target,
  output logic                    ev_ready,
  input  logic                    cfg_wr,
  input  ras_pkg::cfg_addr_t      cfg_addr,
  input  logic [31:0]             cfg_din,
  output logic                    ret_valid,
  output ras_pkg::addr_t          ret_predicted,
  output logic                    ret_mismatch,
  output logic                    ret_underflow,
  output logic                    stack_full,
  output logic                    stack_empty,
  output logic                    overflow,
  output logic                    ras_ena,
  output logic                    mem_rd,
  output logic                    mem_wr,
  output ras_pkg::addr_t          mem_addr,
  output ras_pkg::addr_t          mem_din,
  input  ras_pkg::addr_t          mem_dout,
  input  logic                    mem_rdy
);
  import ras_pkg::*;

  addr_t      base_addr;
  logic       op_valid;
  logic       op_ready;
  ras_op_e    op_kind;
  addr_t      op_addr;
  addr_t      op_target;
  logic       spill_req;
  logic       spill_done;
  addr_t      spill_data;
  logic       fill_req;
  logic       fill_done;
  addr_t      fill_data;
  mem_count_t mem_count;

  ras_config_regs cfg_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_din   (cfg_din),
    .ras_ena   (ras_ena),
    .base_addr (base_addr)
  );

  ras_event_decoder dec_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ena          (ras_ena),
    .ev_valid     (ev_valid),
    .ev_ins       (ev_ins),
    .ev_jal       (ev_jal),
    .ev_rd        (ev_rd),
    .ev_next_addr (ev_next_addr),
    .ev_target    (ev_target),
    .ev_ready     (ev_ready),
    .op_valid     (op_valid),
    .op_kind      (op_kind),
    .op_addr      (op_addr),
    .op_target    (op_target),
    .op_ready     (op_ready)
  );

  ras_stack_buffer buf_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .op_valid      (op_valid),
    .op_kind       (op_kind),
    .op_addr       (op_addr),
    .op_target     (op_target),
    .op_ready      (op_ready),
    .ret_valid     (ret_valid),
    .ret_predicted (ret_predicted),
    .ret_mismatch  (ret_mismatch),
    .ret_underflow (ret_underflow),
    .spill_req     (spill_req),
    .spill_data    (spill_data),
    .spill_done    (spill_done),
    .fill_req      (fill_req),
    .fill_data     (fill_data),
    .fill_done     (fill_done),
    .mem_count     (mem_count),
    .stack_full    (stack_full),
    .stack_empty   (stack_empty),
    .overflow      (overflow)
  );

  ras_spill_engine eng_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .base_addr  (base_addr),
    .spill_req  (spill_req),
    .spill_data (spill_data),
    .fill_req   (fill_req),
    .spill_done (spill_done),
    .fill_done  (fill_done),
    .fill_data  (fill_data),
    .mem_count  (mem_count),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .mem_addr   (mem_addr),
    .mem_din    (mem_din),
    .mem_dout   (mem_dout),
    .mem_rdy    (mem_rdy)
  );

endmodule : ras_top

// ==== rtl/riscv_isa_pkg.sv ====
package riscv_isa_pkg;

  // Raw instruction word as seen at commit
  typedef logic [31:0] ins_t;

  // Architectural register index
  typedef logic [4:0] reg_idx_t;

  // ra, the link register of the standard calling convention
  localparam reg_idx_t LINK_REG = 5'd1;

  // c.jr ra, zero-extended
  localparam ins_t RET_C_WORD = 32'h0000_8082;

  // jalr x0, 0(x1)
  localparam ins_t RET_JALR_WORD = 32'h0000_8067;

endpackage : riscv_isa_pkg

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f ras_top.f --top-module ras_tb -o ras_sim

# The simulator exits nonzero on a fatal check, the search below decides the result
out=$(./obj_dir/ras_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "=== PASS ==="; then
  exit 0
fi
exit 1

// ==== testbench/ras_tb_model.svh ====
// Expected outcome of one return
typedef struct packed {
  addr_t predicted;
  logic  mismatch;
  logic  underflow;
} expect_t;

localparam int TOTAL_DEPTH = STACK_DEPTH + MEM_DEPTH;

// On-chip and backing entries seen as one LIFO
addr_t   ref_stack[$];
bit      ref_overflow = 1'b0;
bit      model_ena = 1'b0;
expect_t expect_q[$];
string   current_test = "none";

task automatic abort_run();
  $display("=== FAIL ===");
  $fatal(1);
endtask

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual) begin
    $display("ERR %s: expected %h, actual %h", what, expected, actual);
    abort_run();
  end
endtask

// Push beyond total capacity is lost
function automatic void model_push(input addr_t next_addr);
  if (ref_stack.size() < TOTAL_DEPTH) begin
    ref_stack.push_back(next_addr);
  end else begin
    ref_overflow = 1'b1;
  end
endfunction

function automatic expect_t model_return(input addr_t target);
  expect_t res;
  if (ref_stack.size() == 0) begin
    res.predicted = '0;
    res.mismatch  = 1'b0;
    res.underflow = 1'b1;
  end else begin
    res.predicted = ref_stack.pop_back();
    res.mismatch  = res.predicted != target;
    res.underflow = 1'b0;
  end
  return res;
endfunction

// Classify one accepted event the way the core stream defines calls and returns
function automatic void model_event(input ins_t ins, input logic jal, input reg_idx_t rd,
                                    input addr_t next_addr, input addr_t target);
  if (model_ena) begin
    if (jal && rd == LINK_REG) begin
      model_push(next_addr);
    end else if (ins == RET_C_WORD || ins == RET_JALR_WORD) begin
      expect_q.push_back(model_return(target));
    end
  end
endfunction

// ==== testbench/ras_tb.sv ====
`timescale 1ns/1ps

module ras_tb;
  import riscv_isa_pkg::*;
  import ras_pkg::*;

  `include "ras_tb_model.svh"

  localparam int    WAIT_LIMIT  = 200;
  localparam int    DRAIN_LIMIT = 4000;
  localparam addr_t WIN_BYTES   = addr_t'(4 * MEM_DEPTH);

  logic       clk = 1'b0;
  logic       rst_n;
  logic       ev_valid;
  ins_t       ev_ins;
  logic       ev_jal;
  reg_idx_t   ev_rd;
  addr_t      ev_next_addr;
  addr_t      ev_target;
  logic       ev_ready;
  logic       cfg_wr;
  cfg_addr_t  cfg_addr;
  logic [31:0] cfg_din;
  logic       ret_valid;
  addr_t      ret_predicted;
  logic       ret_mismatch;
  logic       ret_underflow;
  logic       stack_full;
  logic       stack_empty;
  logic       overflow;
  logic       ras_ena;
  logic       mem_rd;
  logic       mem_wr;
  addr_t      mem_addr;
  addr_t      mem_din;
  addr_t      mem_dout;
  logic       mem_rdy;

  int      seed = 37501;
  addr_t   win_base = '0;
  addr_t   backing [MEM_DEPTH];
  bit      mem_busy = 1'b0;
  int      mem_delay = 0;
  int      spill_writes = 0;
  expect_t exp_ret;

  ras_top ras_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ev_valid      (ev_valid),
    .ev_ins        (ev_ins),
    .ev_jal        (ev_jal),
    .ev_rd         (ev_rd),
    .ev_next_addr  (ev_next_addr),
    .ev_target     (ev_target),
    .ev_ready      (ev_ready),
    .cfg_wr        (cfg_wr),
    .cfg_addr      (cfg_addr),
    .cfg_din       (cfg_din),
    .ret_valid     (ret_valid),
    .ret_predicted (ret_predicted),
    .ret_mismatch  (ret_mismatch),
    .ret_underflow (ret_underflow),
    .stack_full    (stack_full),
    .stack_empty   (stack_empty),
    .overflow      (overflow),
    .ras_ena       (ras_ena),
    .mem_rd        (mem_rd),
    .mem_wr        (mem_wr),
    .mem_addr      (mem_addr),
    .mem_din       (mem_din),
    .mem_dout      (mem_dout),
    .mem_rdy       (mem_rdy)
  );

  always #50 clk = ~clk;

  task automatic serve_memory();
    logic [3:0] slot;
    if (mem_addr < win_base || mem_addr >= win_base + WIN_BYTES || mem_addr[1:0] != 2'b00) begin
      $display("Memory request at %h is outside the window at %h", mem_addr, win_base);
      abort_run();
    end
    slot = 4'((mem_addr - win_base) >> 2);
    if (mem_wr) begin
      backing[slot] = mem_din;
      spill_writes++;
    end else begin
      mem_dout = backing[slot];
    end
  endtask

  // Backing memory raises rdy after 0 to 3 idle cycles and holds it for one cycle
  always begin
    @(posedge clk);
    #1;
    if (mem_rdy) begin
      mem_rdy = 1'b0;
    end else if (mem_wr || mem_rd) begin
      if (!mem_busy) begin
        mem_busy  = 1'b1;
        mem_delay = $unsigned($random(seed)) % 4;
      end
      if (mem_delay == 0) begin
        serve_memory();
        mem_busy = 1'b0;
        mem_rdy  = 1'b1;
      end else begin
        mem_delay--;
      end
    end
  end

  // Every return result against the oldest outstanding expectation
  always begin
    @(posedge clk);
    #1;
    if (ret_valid) begin
      if (expect_q.size() == 0) begin
        $display("Unexpected ret_valid in %s with no return outstanding", current_test);
        abort_run();
      end else begin
        exp_ret = expect_q.pop_front();
        check_value({current_test, " predicted"}, exp_ret.predicted, ret_predicted);
        check_value({current_test, " mismatch"}, 32'(exp_ret.mismatch), 32'(ret_mismatch));
        check_value({current_test, " underflow"}, 32'(exp_ret.underflow),
                    32'(ret_underflow));
      end
    end
  end

  task automatic write_cfg(input cfg_addr_t addr, input logic [31:0] data);
    cfg_wr   = 1'b1;
    cfg_addr = addr;
    cfg_din  = data;
    @(posedge clk);
    #1;
    cfg_wr = 1'b0;
    if (addr == CFG_CTRL) begin
      model_ena = data[0];
    end else if (addr == CFG_BASE) begin
      win_base = data;
    end
  endtask

  task automatic send_event(input ins_t ins, input logic jal, input reg_idx_t rd,
                            input addr_t next_addr, input addr_t target);
    int waited;
    waited       = 0;
    ev_valid     = 1'b1;
    ev_ins       = ins;
    ev_jal       = jal;
    ev_rd        = rd;
    ev_next_addr = next_addr;
    ev_target    = target;
    while (!ev_ready) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timed out in %s waiting for ev_ready", current_test);
        abort_run();
      end
    end
    @(posedge clk);
    #1;
    ev_valid = 1'b0;
    model_event(ins, jal, rd, next_addr, target);
  endtask

  // jal ra, offset
  task automatic do_call(input addr_t next_addr);
    send_event(32'h0000_00ef, 1'b1, LINK_REG, next_addr, next_addr + 32'h100);
  endtask

  task automatic do_return(input addr_t target, input logic compressed);
    send_event(compressed ? RET_C_WORD : RET_JALR_WORD, 1'b0, 5'd0, '0, target);
  endtask

  task automatic wait_returns_done();
    int waited;
    waited = 0;
    while (expect_q.size() != 0 || !ev_ready) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > DRAIN_LIMIT) begin
        $display("Timed out in %s with %0d returns outstanding", current_test,
                 expect_q.size());
        abort_run();
      end
    end
  endtask

  task automatic wait_stack_full();
    int waited;
    waited = 0;
    while (!stack_full) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > DRAIN_LIMIT) begin
        $display("Timed out in %s waiting for stack_full", current_test);
        abort_run();
      end
    end
  endtask

  task automatic wait_overflow();
    int waited;
    waited = 0;
    while (!overflow) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > DRAIN_LIMIT) begin
        $display("Timed out in %s waiting for overflow", current_test);
        abort_run();
      end
    end
  endtask

  task automatic check_empty_flag();
    check_value({current_test, " stack_empty"}, 32'(ref_stack.size() == 0), 32'(stack_empty));
  endtask

  initial begin
    addr_t pushed [TOTAL_DEPTH + 2];
    int    i;
    rst_n        = 1'b0;
    ev_valid     = 1'b0;
    ev_ins       = '0;
    ev_jal       = 1'b0;
    ev_rd        = '0;
    ev_next_addr = '0;
    ev_target    = '0;
    cfg_wr       = 1'b0;
    cfg_addr     = '0;
    cfg_din      = '0;
    mem_dout     = '0;
    mem_rdy      = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    current_test = "reset";
    check_value("reset outputs", 32'd0,
                32'({ev_ready, ret_valid, mem_rd, mem_wr, overflow, ras_ena}));
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    write_cfg(CFG_BASE, 32'h0000_4000);
    write_cfg(CFG_CTRL, 32'h0000_0001);
    check_value("enable", 32'(model_ena), 32'(ras_ena));

    current_test = "matched calls";
    for (i = 0; i < 5; i++) begin
      do_call(32'h0000_1000 + 32'(8 * i));
    end
    for (i = 4; i >= 0; i--) begin
      do_return(32'h0000_1000 + 32'(8 * i), i[0]);
    end
    wait_returns_done();
    check_empty_flag();

    current_test = "mismatch";
    do_call(32'h0000_2004);
    do_call(32'h0000_2104);
    do_return(32'h0000_2200, 1'b0);
    do_return(32'h0000_2004, 1'b1);
    wait_returns_done();
    check_empty_flag();

    // Deep nesting with random addresses
    current_test = "spill and fill";
    spill_writes = 0;
    for (i = 0; i < 20; i++) begin
      pushed[i] = $random(seed) & 32'hffff_fffc;
      do_call(pushed[i]);
    end
    for (i = 19; i >= 0; i--) begin
      do_return(pushed[i], i[0]);
    end
    wait_returns_done();
    check_value("spill and fill memory writes", 32'd1,
                32'(spill_writes >= 20 - STACK_DEPTH));
    check_empty_flag();

    current_test = "overflow and underflow";
    for (i = 0; i < TOTAL_DEPTH + 2; i++) begin
      pushed[i] = 32'h8000_0000 + 32'(4 * i);
      do_call(pushed[i]);
      if (i == TOTAL_DEPTH - 1) begin
        wait_stack_full();
        check_value("overflow at capacity", 32'(ref_overflow), 32'(overflow));
      end
    end
    wait_overflow();
    check_value("stack_full", 32'(ref_stack.size() == TOTAL_DEPTH), 32'(stack_full));
    for (i = TOTAL_DEPTH - 1; i >= 0; i--) begin
      do_return(pushed[i], i[0]);
    end
    do_return(32'h0000_1234, 1'b0);
    do_return(32'h0000_1238, 1'b1);
    wait_returns_done();
    check_empty_flag();

    current_test = "disable and filter";
    do_call(32'h0000_3004);
    do_call(32'h0000_3104);
    // jal x0, addi, jalr through x5
    send_event(32'h0000_006f, 1'b1, 5'd0, 32'h0000_3204, 32'h0000_3300);
    send_event(32'h0000_0013, 1'b0, 5'd0, 32'h0000_3208, 32'h0000_3304);
    send_event(32'h0002_8067, 1'b0, 5'd0, 32'h0000_320c, 32'h0000_3308);
    write_cfg(3'd3, 32'h0000_0000);
    check_value("enable after unmapped write", 32'(model_ena), 32'(ras_ena));
    write_cfg(CFG_CTRL, 32'h0000_0000);
    check_value("enable cleared", 32'(model_ena), 32'(ras_ena));
    do_return(32'h0000_3104, 1'b1);
    do_call(32'h0000_3777);
    write_cfg(CFG_CTRL, 32'h0000_0001);
    do_return(32'h0000_3104, 1'b0);
    do_return(32'h0000_3004, 1'b1);
    wait_returns_done();
    check_empty_flag();

    if (expect_q.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("Returns still outstanding at the end of the run");
      abort_run();
    end
  end

endmodule : ras_tb
